// ==== hw/icache_pkg.sv ====
// Instruction cache package: address, block and tag types, geometry defaults
`default_nettype none

package icache_pkg;

  // ==============================
  // Address and block geometry
  // ==============================

  // Byte address width
  localparam int ADDR_BITS = 32;

  // One cache block, 16 bytes
  localparam int BLK_BITS = 128;

  // Byte offset inside a block
  localparam int BOFF_BITS = $clog2(BLK_BITS / 8);

  // Default geometry, both powers of two, at least 2 ways
  localparam int DEF_NUM_WAY = 4;
  localparam int DEF_NUM_SET = 8;

  // Tag sized for the smallest set count (2 sets, 1 index bit)
  localparam int MIN_IDX_BITS = 1;
  localparam int TAG_BITS = ADDR_BITS - BOFF_BITS - MIN_IDX_BITS;

  // ==============================
  // Types
  // ==============================

  typedef logic [ADDR_BITS-1:0] addr_t;

  typedef logic [BLK_BITS-1:0] blk_t;

  // Tag RAM entry, upper tag bits stay zero for larger set counts
  typedef struct packed {
    logic                valid;
    logic [TAG_BITS-1:0] tag;
  } tag_entry_t;

endpackage

`default_nettype wire

// ==== hw/array_if.sv ====
// Way array interface and lookup to fill control pipeline interface
`timescale 1ns/10ps
`default_nettype none

// Array port bundle shared by the tag RAM, the data RAM and fill control
interface array_if #(
  parameter int NUM_WAY = icache_pkg::DEF_NUM_WAY,
  parameter int NUM_SET = icache_pkg::DEF_NUM_SET
);
  import icache_pkg::*;

  localparam int IDX_BITS = $clog2(NUM_SET);

  // Shared set index for both arrays
  logic [IDX_BITS-1:0]       idx;
  // Write enables, one bit per way
  logic [NUM_WAY-1:0]        tag_we;
  logic [NUM_WAY-1:0]        data_we;
  // Write payloads
  tag_entry_t                wtag;
  blk_t                      wblk;
  // Registered read payloads per way
  tag_entry_t [NUM_WAY-1:0]  rtag;
  blk_t [NUM_WAY-1:0]        rblk;

  modport ctrl (output idx, tag_we, data_we, wtag, wblk, input rtag, rblk);
  modport store (input idx, tag_we, data_we, wtag, wblk, output rtag, rblk);
endinterface

// Request register and sweep state passed from lookup to fill control
interface pipe_if #(
  parameter int NUM_SET = icache_pkg::DEF_NUM_SET
);
  import icache_pkg::*;

  localparam int IDX_BITS = $clog2(NUM_SET);

  logic                req_q_valid;
  addr_t               req_q_addr;
  // Array read index for the next cycle
  logic [IDX_BITS-1:0] rd_idx;
  logic                sweep_active;
  logic [IDX_BITS-1:0] sweep_idx;
  // High while a miss is outstanding
  logic                stall;

  modport lookup (output req_q_valid, req_q_addr, rd_idx, sweep_active, sweep_idx, input stall);
  modport ctrl (input req_q_valid, req_q_addr, rd_idx, sweep_active, sweep_idx, output stall);
endinterface

`default_nettype wire

// ==== hw/icache_way_ram.sv ====
// Per-way synchronous single-port RAM with a payload type parameter
`timescale 1ns/10ps
`default_nettype none

module icache_way_ram #(
  parameter int  NUM_WAY = icache_pkg::DEF_NUM_WAY,
  parameter int  NUM_SET = icache_pkg::DEF_NUM_SET,
  // Entry payload, a tag entry or a full block
  parameter type entry_t = logic
) (
  input  wire logic                       clk_i,
  input  wire logic                       rst_ni,
  // One index shared by all ways
  input  wire logic [$clog2(NUM_SET)-1:0] idx_i,
  // Way mask, several ways may write the same entry
  input  wire logic [NUM_WAY-1:0]         we_i,
  input  wire entry_t                     wdata_i,
  // Registered read, one entry per way
  output entry_t [NUM_WAY-1:0]            rdata_o
);

  localparam int IDX_BITS = $clog2(NUM_SET);

  // ==============================
  // Storage
  // ==============================

  // NUM_WAY banks of NUM_SET entries
  entry_t mem_q [NUM_WAY][NUM_SET];

  // Write index and read index are the same port
  logic [IDX_BITS-1:0] addr;

  assign addr = idx_i;

  // ==============================
  // Access
  // ==============================

  // Read returns the old entry when the same cycle writes
  // Writes are held off while reset is asserted
  always_ff @(posedge clk_i) begin
    for (int w = 0; w < NUM_WAY; w++) begin
      if (rst_ni && we_i[w]) begin
        mem_q[w][addr] <= wdata_i;
      end
      rdata_o[w] <= mem_q[w][addr];
    end
  end

endmodule

`default_nettype wire

// ==== hw/icache_lookup.sv ====
// Lookup stage: request register, index select and invalidate sweep counter
`timescale 1ns/10ps
`default_nettype none

module icache_lookup #(
  parameter int NUM_SET = icache_pkg::DEF_NUM_SET
) (
  input  wire logic              clk_i,
  input  wire logic              rst_ni,
  input  wire logic              flush_i,
  input  wire logic              req_valid_i,
  input  wire icache_pkg::addr_t req_addr_i,
  output logic                   req_ready_o,
  pipe_if.lookup                 pipe
);
  import icache_pkg::*;

  localparam int IDX_BITS = $clog2(NUM_SET);

  logic                accept;
  logic                req_valid_q;
  addr_t               req_addr_q;
  logic                sweep_active_q;
  logic [IDX_BITS-1:0] sweep_idx_q;
  logic                sweep_last;

  // ==============================
  // Request handshake
  // ==============================

  // Closed during a sweep, a miss, and the cycle that starts a sweep
  assign req_ready_o = !sweep_active_q && !pipe.stall && !flush_i;
  assign accept = req_valid_i && req_ready_o;

  // Read at the incoming index so tags are ready the next cycle
  // While closed, keep rereading the set of the held request
  assign pipe.rd_idx = req_ready_o ? req_addr_i[BOFF_BITS +: IDX_BITS]
                                   : req_addr_q[BOFF_BITS +: IDX_BITS];

  // Valid for exactly one cycle per accepted request
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      req_valid_q <= 1'b0;
    end else begin
      req_valid_q <= accept;
    end
  end

  // Address is held through a miss for the refill write
  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_addr_q <= req_addr_i;
    end
  end

  // ==============================
  // Invalidate sweep
  // ==============================

  assign sweep_last = (sweep_idx_q == IDX_BITS'(NUM_SET - 1));

  // Starts at reset, or after a flush when no miss is pending
  // One set per cycle, NUM_SET cycles in total
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      sweep_active_q <= 1'b1;
      sweep_idx_q    <= '0;
    end else if (sweep_active_q) begin
      if (sweep_last) begin
        sweep_active_q <= 1'b0;
        sweep_idx_q    <= '0;
      end else begin
        sweep_idx_q <= sweep_idx_q + 1'b1;
      end
    end else if (flush_i && !pipe.stall) begin
      sweep_active_q <= 1'b1;
    end
  end

  assign pipe.req_q_valid  = req_valid_q;
  assign pipe.req_q_addr   = req_addr_q;
  assign pipe.sweep_active = sweep_active_q;
  assign pipe.sweep_idx    = sweep_idx_q;

endmodule

`default_nettype wire

// ==== hw/icache_plru.sv ====
// Tree pseudo-LRU state per set with update and victim selection
`timescale 1ns/10ps
`default_nettype none

module icache_plru #(
  parameter int NUM_WAY = icache_pkg::DEF_NUM_WAY,
  parameter int NUM_SET = icache_pkg::DEF_NUM_SET
) (
  input  wire logic                       clk_i,
  input  wire logic                       rst_ni,
  // Set of the registered request, or the swept set
  input  wire logic [$clog2(NUM_SET)-1:0] idx_i,
  // Hit or fill on access_way_i
  input  wire logic                       access_i,
  input  wire logic [NUM_WAY-1:0]         access_way_i,
  input  wire logic [NUM_WAY-1:0]         valid_vec_i,
  // Sweep clears the set at idx_i
  input  wire logic                       clear_i,
  output logic [NUM_WAY-1:0]              evict_way_o
);

  localparam int LVLS = $clog2(NUM_WAY);

  // Heap order, node n has children 2n+1 (lower) and 2n+2 (upper)
  logic [NUM_WAY-2:0] tree_q [NUM_SET];
  logic [NUM_WAY-2:0] node;
  logic [NUM_WAY-2:0] node_upd;
  logic [NUM_WAY-1:0] tree_way;
  logic [NUM_WAY-1:0] invalid_way;

  assign node = tree_q[idx_i];

  // ==============================
  // Victim selection
  // ==============================

  // Lowest clear bit of the valid vector
  assign invalid_way = ~valid_vec_i & (valid_vec_i + 1'b1);

  // Follow the bits from the root, 0 goes low and 1 goes high
  always_comb begin
    int unsigned n;
    n = 0;
    for (int l = 0; l < LVLS; l++) begin
      n = 2 * n + 1 + node[n];
    end
    tree_way = '0;
    // Leaves follow the NUM_WAY-1 inner nodes
    tree_way[n - (NUM_WAY - 1)] = 1'b1;
  end

  // Any invalid way beats the tree
  assign evict_way_o = (|invalid_way) ? invalid_way : tree_way;

  // ==============================
  // Update
  // ==============================

  always_comb begin
    int unsigned n;
    int unsigned way;
    logic        dir;
    // Way mask to way number
    way = 0;
    for (int w = 0; w < NUM_WAY; w++) begin
      if (access_way_i[w]) begin
        way = w;
      end
    end
    node_upd = node;
    n = 0;
    // Each node on the path points to the other half
    for (int l = 0; l < LVLS; l++) begin
      dir = way[LVLS - 1 - l];
      node_upd[n] = ~dir;
      n = 2 * n + 1 + dir;
    end
  end

  // Clear wins over access, sweep and access never overlap anyway
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int s = 0; s < NUM_SET; s++) begin
        tree_q[s] <= '0;
      end
    end else if (clear_i) begin
      tree_q[idx_i] <= '0;
    end else if (access_i) begin
      tree_q[idx_i] <= node_upd;
    end
  end

endmodule

`default_nettype wire

// ==== hw/icache_fill_ctrl.sv ====
// Fill control: hit compare, miss and refill, array write steering, response
`timescale 1ns/10ps
`default_nettype none

module icache_fill_ctrl #(
  parameter int NUM_WAY = icache_pkg::DEF_NUM_WAY,
  parameter int NUM_SET = icache_pkg::DEF_NUM_SET
) (
  input  wire logic               clk_i,
  input  wire logic               rst_ni,
  pipe_if.ctrl                    pipe,
  array_if.ctrl                   arr,
  // PLRU
  input  wire logic [NUM_WAY-1:0] evict_way_i,
  output logic                    plru_access_o,
  output logic [NUM_WAY-1:0]      plru_way_o,
  output logic [NUM_WAY-1:0]      valid_vec_o,
  // Lower memory
  output logic                    mem_req_valid_o,
  output icache_pkg::addr_t       mem_req_addr_o,
  input  wire logic               mem_res_valid_i,
  input  wire icache_pkg::blk_t   mem_res_blk_i,
  // Response
  output logic                    res_valid_o,
  output logic                    res_miss_o,
  output icache_pkg::blk_t        res_blk_o
);
  import icache_pkg::*;

  localparam int IDX_BITS = $clog2(NUM_SET);
  localparam int TAG_W = ADDR_BITS - BOFF_BITS - IDX_BITS;

  logic [IDX_BITS-1:0] req_idx;
  logic [TAG_W-1:0]    req_tag;
  logic [NUM_WAY-1:0]  hit_vec;
  logic                hit_now;
  logic                miss_now;
  logic                miss_q;
  logic                outstanding;
  logic                refill;
  blk_t                hit_blk;

  assign req_idx = pipe.req_q_addr[BOFF_BITS +: IDX_BITS];
  assign req_tag = pipe.req_q_addr[ADDR_BITS-1 -: TAG_W];

  // ==============================
  // Hit compare
  // ==============================

  // Only the tag bits of this geometry take part
  always_comb begin
    for (int w = 0; w < NUM_WAY; w++) begin
      valid_vec_o[w] = arr.rtag[w].valid;
      hit_vec[w]     = arr.rtag[w].valid && (arr.rtag[w].tag[TAG_W-1:0] == req_tag);
    end
  end

  // One-hot hit, so an OR of masked blocks
  always_comb begin
    hit_blk = '0;
    for (int w = 0; w < NUM_WAY; w++) begin
      hit_blk = hit_blk | (arr.rblk[w] & {BLK_BITS{hit_vec[w]}});
    end
  end

  // Request register is valid for one cycle, so these are single pulses
  assign hit_now  = pipe.req_q_valid && (|hit_vec);
  assign miss_now = pipe.req_q_valid && !(|hit_vec);

  // ==============================
  // Miss and refill
  // ==============================

  // First miss cycle comes from the compare, later ones from the flag
  assign outstanding = miss_now || miss_q;
  assign refill      = outstanding && mem_res_valid_i;
  assign pipe.stall  = outstanding;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      miss_q <= 1'b0;
    end else begin
      miss_q <= outstanding && !mem_res_valid_i;
    end
  end

  // Level request, block aligned
  assign mem_req_valid_o = outstanding;
  assign mem_req_addr_o  = {pipe.req_q_addr[ADDR_BITS-1:BOFF_BITS], {BOFF_BITS{1'b0}}};

  // Sweep first, then refill, else plain read
  always_comb begin
    arr.idx           = pipe.rd_idx;
    arr.tag_we        = '0;
    arr.data_we       = '0;
    arr.wblk          = mem_res_blk_i;
    arr.wtag          = '0;
    arr.wtag.valid    = 1'b1;
    arr.wtag.tag[TAG_W-1:0] = req_tag;
    if (pipe.sweep_active) begin
      // Invalidate every way of the swept set
      arr.idx    = pipe.sweep_idx;
      arr.tag_we = '1;
      arr.wtag   = '0;
    end else if (refill) begin
      arr.idx     = req_idx;
      arr.tag_we  = evict_way_i;
      arr.data_we = evict_way_i;
    end
  end

  // PLRU touch on hit or fill
  assign plru_access_o = hit_now || refill;
  assign plru_way_o    = hit_now ? hit_vec : evict_way_i;

  // ==============================
  // Response
  // ==============================

  assign res_valid_o = hit_now || refill;
  assign res_miss_o  = refill;
  // Refill data bypasses the arrays
  assign res_blk_o   = refill ? mem_res_blk_i : hit_blk;

endmodule

`default_nettype wire

// ==== hw/icache_top.sv ====
// Instruction cache top: lookup, fill control, PLRU and the tag and data RAMs
`timescale 1ns/10ps
`default_nettype none

module icache_top #(
  parameter int NUM_WAY = icache_pkg::DEF_NUM_WAY,
  parameter int NUM_SET = icache_pkg::DEF_NUM_SET
) (
  input  wire logic              clk_i,
  input  wire logic              rst_ni,
  input  wire logic              flush_i,
  // Request
  input  wire logic              req_valid_i,
  input  wire icache_pkg::addr_t req_addr_i,
  output logic                   req_ready_o,
  // Response
  output logic                   res_valid_o,
  output logic                   res_miss_o,
  output icache_pkg::blk_t       res_blk_o,
  // Lower memory
  output logic                   mem_req_valid_o,
  output icache_pkg::addr_t      mem_req_addr_o,
  input  wire logic              mem_res_valid_i,
  input  wire icache_pkg::blk_t  mem_res_blk_i
);
  import icache_pkg::*;

  localparam int IDX_BITS = $clog2(NUM_SET);

  logic [NUM_WAY-1:0]  evict_way;
  logic [NUM_WAY-1:0]  plru_way;
  logic [NUM_WAY-1:0]  valid_vec;
  logic                plru_access;
  logic [IDX_BITS-1:0] plru_idx;

  pipe_if #(.NUM_SET(NUM_SET)) pipe ();
  array_if #(.NUM_WAY(NUM_WAY), .NUM_SET(NUM_SET)) arr ();

  // ==============================
  // Stages
  // ==============================

  icache_lookup #(.NUM_SET(NUM_SET)) i_lookup (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (flush_i),
    .req_valid_i (req_valid_i),
    .req_addr_i  (req_addr_i),
    .req_ready_o (req_ready_o),
    .pipe        (pipe.lookup)
  );

  icache_fill_ctrl #(.NUM_WAY(NUM_WAY), .NUM_SET(NUM_SET)) i_fill_ctrl (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .pipe            (pipe.ctrl),
    .arr             (arr.ctrl),
    .evict_way_i     (evict_way),
    .plru_access_o   (plru_access),
    .plru_way_o      (plru_way),
    .valid_vec_o     (valid_vec),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_addr_o  (mem_req_addr_o),
    .mem_res_valid_i (mem_res_valid_i),
    .mem_res_blk_i   (mem_res_blk_i),
    .res_valid_o     (res_valid_o),
    .res_miss_o      (res_miss_o),
    .res_blk_o       (res_blk_o)
  );

  // ==============================
  // PLRU and arrays
  // ==============================

  // PLRU follows the registered request, or the swept set
  assign plru_idx = pipe.sweep_active ? pipe.sweep_idx
                                      : pipe.req_q_addr[BOFF_BITS +: IDX_BITS];

  icache_plru #(.NUM_WAY(NUM_WAY), .NUM_SET(NUM_SET)) i_plru (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .idx_i        (plru_idx),
    .access_i     (plru_access),
    .access_way_i (plru_way),
    .valid_vec_i  (valid_vec),
    .clear_i      (pipe.sweep_active),
    .evict_way_o  (evict_way)
  );

  icache_way_ram #(.NUM_WAY(NUM_WAY), .NUM_SET(NUM_SET), .entry_t(tag_entry_t)) i_tag_ram (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .idx_i   (arr.idx),
    .we_i    (arr.tag_we),
    .wdata_i (arr.wtag),
    .rdata_o (arr.rtag)
  );

  icache_way_ram #(.NUM_WAY(NUM_WAY), .NUM_SET(NUM_SET), .entry_t(blk_t)) i_data_ram (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .idx_i   (arr.idx),
    .we_i    (arr.data_we),
    .wdata_i (arr.wblk),
    .rdata_o (arr.rblk)
  );

endmodule

`default_nettype wire

// ==== tb/tb_clkgen.sv ====
// Testbench clock and reset generator
`timescale 1ns/10ps
`default_nettype none

module tb_clkgen #(
  parameter int PERIOD_NS  = 40,
  parameter int RST_CYCLES = 8
) (
  output logic clk_o,
  output logic rst_no
);

  // Free running clock
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Reset low for RST_CYCLES rising edges, released on an edge
  initial begin
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

`default_nettype wire

// ==== tb/icache_tb.sv ====
// Instruction cache testbench with random requests, a memory responder, a reference model and checks
`timescale 1ns/10ps
`default_nettype none

module icache_tb;
  import icache_pkg::*;

  localparam int NUM_WAY   = DEF_NUM_WAY;
  localparam int NUM_SET   = DEF_NUM_SET;
  localparam int IDX_BITS  = $clog2(NUM_SET);
  localparam int LVLS      = $clog2(NUM_WAY);
  localparam int NUM_LINES = 48;
  localparam int N_FIRST   = 400;
  localparam int N_SECOND  = 200;
  localparam int NUM_REQ   = N_FIRST + NUM_LINES + N_SECOND;
  localparam int TIMEOUT_CYCLES = 20 * NUM_REQ + 500;
  localparam int DRAIN_CYCLES   = 64;
  localparam logic [31:0] SEED  = 32'd32172;

  // Expected response in acceptance order
  typedef struct packed {
    logic        miss;
    blk_t        blk;
    addr_t       addr;
    int unsigned acc_cycle;
  } exp_t;

  logic  clk_i;
  logic  rst_ni;
  logic  flush_i;
  logic  req_valid_i;
  addr_t req_addr_i;
  logic  req_ready_o;
  logic  res_valid_o;
  logic  res_miss_o;
  blk_t  res_blk_o;
  logic  mem_req_valid_o;
  addr_t mem_req_addr_o;
  logic  mem_res_valid_i;
  blk_t  mem_res_blk_i;

  exp_t        exp_q[$];
  addr_t       pool [NUM_LINES];
  int unsigned cycle_cnt = 0;
  logic [31:0] stim_state;
  logic [31:0] mem_state;

  // Model state per set
  logic [ADDR_BITS-1:0] m_tag   [NUM_SET][NUM_WAY];
  bit                   m_valid [NUM_SET][NUM_WAY];
  logic [NUM_WAY-2:0]   m_plru  [NUM_SET];

  tb_clkgen #(.PERIOD_NS(40), .RST_CYCLES(8)) i_clkgen (
    .clk_o  (clk_i),
    .rst_no (rst_ni)
  );

  icache_top #(.NUM_WAY(NUM_WAY), .NUM_SET(NUM_SET)) UUT (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (flush_i),
    .req_valid_i     (req_valid_i),
    .req_addr_i      (req_addr_i),
    .req_ready_o     (req_ready_o),
    .res_valid_o     (res_valid_o),
    .res_miss_o      (res_miss_o),
    .res_blk_o       (res_blk_o),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_addr_o  (mem_req_addr_o),
    .mem_res_valid_i (mem_res_valid_i),
    .mem_res_blk_i   (mem_res_blk_i)
  );

  // ==============================
  // Random numbers and line data
  // ==============================

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] stim_rand();
    stim_state = xorshift(stim_state);
    return stim_state;
  endfunction

  // Block content from four xorshift steps on the line address
  function automatic blk_t line_block(input addr_t a);
    logic [31:0] s;
    blk_t        b;
    s = (a >> BOFF_BITS) ^ 32'h5bd1e995;
    if (s == 0) begin
      s = 32'h1;
    end
    for (int k = 0; k < 4; k++) begin
      s = xorshift(s);
      b[32*k +: 32] = s;
    end
    return b;
  endfunction

  // ==============================
  // Failure reporting and checks
  // ==============================

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "Run stopped at the first failure");
  endtask

  task automatic check_blk(input blk_t got, input blk_t exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("[ERROR] %0d ns: %s got %h expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_miss(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("[ERROR] %0d ns: %s got %b expected %b", $time, what, got, exp));
    end
  endtask

  task automatic check_addr(input addr_t got, input addr_t exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("[ERROR] %0d ns: %s got %h expected %h", $time, what, got, exp));
    end
  endtask

  // ==============================
  // Reference model
  // ==============================

  task automatic model_flush();
    for (int s = 0; s < NUM_SET; s++) begin
      m_plru[s] = '0;
      for (int w = 0; w < NUM_WAY; w++) begin
        m_valid[s][w] = 1'b0;
        m_tag[s][w]   = '0;
      end
    end
  endtask

  // Lowest invalid way first, otherwise walk the tree
  function automatic int unsigned pick_victim(input int unsigned s);
    int unsigned way;
    int unsigned node;
    bit          found;
    found = 1'b0;
    way   = 0;
    for (int w = NUM_WAY - 1; w >= 0; w--) begin
      if (!m_valid[s][w]) begin
        way   = w;
        found = 1'b1;
      end
    end
    if (!found) begin
      node = 0;
      for (int l = 0; l < LVLS; l++) begin
        way  = 2 * way + m_plru[s][node];
        node = 2 * node + 1 + m_plru[s][node];
      end
    end
    return way;
  endfunction

  // Nodes on the path point away from the touched way
  task automatic touch_plru(input int unsigned s, input int unsigned way);
    int unsigned node;
    int unsigned dir;
    node = 0;
    for (int l = 0; l < LVLS; l++) begin
      dir = (way >> (LVLS - 1 - l)) & 1;
      m_plru[s][node] = (dir == 0);
      node = 2 * node + 1 + dir;
    end
  endtask

  task automatic model_access(input addr_t a);
    int unsigned          set_n;
    int unsigned          way_n;
    logic [ADDR_BITS-1:0] tag;
    bit                   hit;
    exp_t                 e;
    set_n = (a >> BOFF_BITS) % NUM_SET;
    tag   = a >> (BOFF_BITS + IDX_BITS);
    hit   = 1'b0;
    way_n = 0;
    for (int w = 0; w < NUM_WAY; w++) begin
      if (m_valid[set_n][w] && m_tag[set_n][w] == tag) begin
        hit   = 1'b1;
        way_n = w;
      end
    end
    if (!hit) begin
      way_n = pick_victim(set_n);
      m_valid[set_n][way_n] = 1'b1;
      m_tag[set_n][way_n]   = tag;
    end
    touch_plru(set_n, way_n);
    e.miss      = !hit;
    e.addr      = (a >> BOFF_BITS) << BOFF_BITS;
    e.blk       = line_block(e.addr);
    e.acc_cycle = cycle_cnt;
    exp_q.push_back(e);
  endtask

  // ==============================
  // Monitor on the falling edge
  // ==============================

  always @(negedge clk_i) begin : monitor
    exp_t head;
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      abort_run($sformatf("Timeout: test did not finish within %0d cycles", TIMEOUT_CYCLES));
    end
    if (rst_ni === 1'b1) begin
      // A miss raises the memory request one cycle after acceptance
      if (exp_q.size() != 0 && exp_q[0].miss && cycle_cnt == exp_q[0].acc_cycle + 1) begin
        check_miss(mem_req_valid_o, 1'b1, "memory request after a miss");
      end
      if (mem_req_valid_o) begin
        if (exp_q.size() == 0) begin
          abort_run("Memory request seen while no request was pending");
        end
        head = exp_q[0];
        check_miss(1'b1, head.miss, "memory request, miss flag of pending request");
        check_addr(mem_req_addr_o, head.addr, "memory request address");
        if (mem_res_valid_i) begin
          check_miss(res_valid_o, 1'b1, "response in the refill cycle");
        end
      end
      if (res_valid_o) begin
        if (exp_q.size() == 0) begin
          abort_run("Response seen while no request was pending");
        end
        head = exp_q.pop_front();
        check_miss(res_miss_o, head.miss, "response miss flag");
        check_blk(res_blk_o, head.blk, "response block");
        if (head.miss) begin
          check_miss(mem_res_valid_i, 1'b1, "memory response with a miss response");
        end
      end
      // Hits answer in the very next cycle
      if (exp_q.size() != 0 && !exp_q[0].miss && cycle_cnt > exp_q[0].acc_cycle) begin
        abort_run($sformatf("[ERROR] %0d ns: hit response missing", $time));
      end
      if (flush_i) begin
        model_flush();
      end
      if (req_valid_i && req_ready_o) begin
        model_access(req_addr_i);
      end
    end
  end

  // ==============================
  // Lower memory responder
  // ==============================

  initial begin : mem_responder
    addr_t       line;
    int unsigned lat;
    mem_res_valid_i = 1'b0;
    mem_res_blk_i   = '0;
    mem_state       = SEED;
    forever begin
      @(negedge clk_i);
      if (rst_ni === 1'b1 && mem_req_valid_o) begin
        line      = mem_req_addr_o;
        mem_state = xorshift(mem_state);
        lat       = mem_state % 6;
        repeat (lat) @(posedge clk_i);
        @(posedge clk_i);
        mem_res_valid_i <= 1'b1;
        mem_res_blk_i   <= line_block(line);
        @(posedge clk_i);
        mem_res_valid_i <= 1'b0;
      end
    end
  end

  // ==============================
  // Stimulus
  // ==============================

  // Returns on the falling edge before the accepting rising edge
  task automatic send_req(input addr_t a);
    @(posedge clk_i);
    req_valid_i <= 1'b1;
    req_addr_i  <= a;
    @(negedge clk_i);
    while (req_ready_o !== 1'b1) begin
      @(negedge clk_i);
    end
  endtask

  task automatic idle_cycles(input int unsigned n);
    repeat (n) begin
      @(posedge clk_i);
      req_valid_i <= 1'b0;
    end
  endtask

  // Any word inside a random pool line with short gaps now and then
  task automatic run_random(input int unsigned n);
    logic [31:0] r;
    for (int unsigned i = 0; i < n; i++) begin
      r = stim_rand();
      send_req(pool[r % NUM_LINES] | addr_t'((r >> 24) & 32'hC));
      r = stim_rand();
      if (r % 4 == 0) begin
        idle_cycles(1 + (r >> 8) % 2);
      end
    end
    idle_cycles(1);
  endtask

  task automatic drain();
    for (int k = 0; k < DRAIN_CYCLES && exp_q.size() != 0; k++) begin
      @(posedge clk_i);
    end
  endtask

  // Ready stays low for one cycle per set while the outputs stay quiet
  task automatic check_sweep(input string when);
    int unsigned n;
    n = 0;
    @(negedge clk_i);
    while (req_ready_o !== 1'b1) begin
      check_miss(res_valid_o, 1'b0, {"response valid during sweep ", when});
      check_miss(mem_req_valid_o, 1'b0, {"memory request during sweep ", when});
      n++;
      @(negedge clk_i);
    end
    if (n != NUM_SET) begin
      abort_run($sformatf("[ERROR] %0d ns: ready low for %0d cycles %s, expected %0d",
                          $time, n, when, NUM_SET));
    end
  endtask

  initial begin : stimulus
    flush_i     = 1'b0;
    req_valid_i = 1'b0;
    req_addr_i  = '0;
    stim_state  = SEED;
    // Six tags per set so lines outnumber ways
    for (int i = 0; i < NUM_LINES; i++) begin
      pool[i] = 32'h0040_0000 + ((i % NUM_SET) << BOFF_BITS) + ((i / NUM_SET) << 12);
    end
    model_flush();
    wait (rst_ni === 1'b1);
    check_sweep("after reset");
    run_random(N_FIRST);
    drain();
    if (exp_q.size() != 0) begin
      abort_run("Responses still missing before the flush");
    end
    // Flush while idle
    @(posedge clk_i);
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
    check_sweep("after flush");
    // Every line once and all of them miss again
    for (int i = 0; i < NUM_LINES; i++) begin
      send_req(pool[i]);
    end
    idle_cycles(1);
    run_random(N_SECOND);
    drain();
    idle_cycles(4);
    if (exp_q.size() == 0) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      abort_run($sformatf("Run ended with %0d responses missing", exp_q.size()));
    end
  end

endmodule

`default_nettype wire

// ==== build.f ====
hw/icache_pkg.sv
hw/array_if.sv
hw/icache_way_ram.sv
hw/icache_lookup.sv
hw/icache_plru.sv
hw/icache_fill_ctrl.sv
hw/icache_top.sv
tb/tb_clkgen.sv
tb/icache_tb.sv

// ==== Bender.yml ====
package:
  name: icache

sources:
  - hw/icache_pkg.sv
  - hw/array_if.sv
  - hw/icache_way_ram.sv
  - hw/icache_lookup.sv
  - hw/icache_plru.sv
  - hw/icache_fill_ctrl.sv
  - hw/icache_top.sv
  - target: test
    files:
      - tb/tb_clkgen.sv
      - tb/icache_tb.sv
